// ==== alu_stage.sv ====
// alu and result register; result feeds the outputs, ram writeback and forwarding
`timescale 1ns/100ps
`default_nettype none

module alu_stage
(
   input  logic              clk_a,
   input  logic              reset,

   input  logic              op_valid,
   input  mmem_pkg::word_t   op_m,
   input  mmem_pkg::word_t   op_a,
   input  mmem_pkg::maddr_t  op_dest,
   input  mmem_pkg::alu_op_t op_alu,

   output logic              res_valid,
   output mmem_pkg::maddr_t  res_dest,
   output mmem_pkg::word_t   res_data
);

   import mmem_pkg::*;

   word_t alu_out;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // operation select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb
   begin
      case (op_alu)
         OP_ADD:
         begin
            alu_out = op_m + op_a;
         end
         OP_SUB:
         begin
            alu_out = op_m - op_a;
         end
         OP_AND:
         begin
            alu_out = op_m & op_a;
         end
         OP_OR:
         begin
            alu_out = op_m | op_a;
         end
         OP_XOR:
         begin
            alu_out = op_m ^ op_a;
         end
         OP_PASS_M:
         begin
            alu_out = op_m;
         end
         OP_PASS_A:
         begin
            alu_out = op_a;
         end
         OP_SHL_M:
         begin
            // low bit fills with zero
            alu_out = {op_m[DATA_W-2:0], 1'b0};
         end
         default:
         begin
            alu_out = op_m;
         end
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // result register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         res_valid <= 1'b0;
      end
      else
      begin
         res_valid <= op_valid;
      end
   end

   // payload held between instructions
   always_ff @(posedge clk_a)
   begin
      if (op_valid)
      begin
         res_dest <= op_dest;
         res_data <= alu_out;
      end
   end

   // fetch stage must hand over a defined op and destination
   a_op_known : assert property (@(posedge clk_a) disable iff (reset)
      op_valid |-> !$isunknown({op_alu, op_dest}))
      else $error("valid operand stage with unknown op or destination");

endmodule

`default_nettype wire

// ==== mmem_checker.sv ====
// testbench monitor: matches each result of the scratchpad slice against the queued expectation
`timescale 1ns/100ps
`default_nettype none

module mmem_checker
(
   input  logic             clk_a,
   input  logic             reset,
   input  logic             issue,
   input  logic             result_valid,
   input  mmem_pkg::word_t  result,
   input  mmem_pkg::maddr_t result_dest
);

   import mmem_pkg::*;

   // expected results in issue order
   string  name_q[$];
   word_t  data_q[$];
   maddr_t dest_q[$];

   int mismatch_count = 0;
   int timing_count   = 0;
   int missing_count  = 0;

   logic [RESULT_LATENCY-1:0] issue_hist;
   logic   expect_now;
   string  exp_name;
   word_t  exp_data;
   maddr_t exp_dest;

   task automatic push_expected(input string name, input word_t data, input maddr_t dest);
      name_q.push_back(name);
      data_q.push_back(data);
      dest_q.push_back(dest);
   endtask

   // whatever is still queued never came out of the dut
   task automatic report_pending();
      for (int i = 0; i < name_q.size(); i++)
      begin
         $display("expected result for %s at dest %0d never arrived", name_q[i], dest_q[i]);
      end
      missing_count = name_q.size();
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // compare, mid cycle when dut outputs are settled
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always @(negedge clk_a)
   begin
      if (reset)
      begin
         issue_hist = '0;
      end
      else
      begin
         // issue seen here is sampled on the next edge
         expect_now = issue_hist[RESULT_LATENCY-1];
         issue_hist = {issue_hist[RESULT_LATENCY-2:0], issue};
         if (result_valid !== 1'b0 && !expect_now)
         begin
            $display("result at dest %0d arrived without an issue %0d edges earlier",
                     result_dest, RESULT_LATENCY);
            timing_count++;
         end
         else if (expect_now && name_q.size() == 0)
         begin
            $display("result at dest %0d arrived with nothing expected", result_dest);
            timing_count++;
         end
         else if (expect_now)
         begin
            exp_name = name_q.pop_front();
            exp_data = data_q.pop_front();
            exp_dest = dest_q.pop_front();
            if (result_valid !== 1'b1)
            begin
               $display("result for %s did not appear %0d edges after issue",
                        exp_name, RESULT_LATENCY);
               timing_count++;
            end
            else
            begin
               if (result !== exp_data)
               begin
                  $display("mismatch %s expected %h actual %h", exp_name, exp_data, result);
                  mismatch_count++;
               end
               if (result_dest !== exp_dest)
               begin
                  $display("mismatch %s dest expected %0d actual %0d",
                           exp_name, exp_dest, result_dest);
                  mismatch_count++;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== mmem_pkg.sv ====
// shared widths, types and pipeline constants for the scratchpad slice; import where needed
`default_nettype none

package mmem_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int unsigned DATA_W = 32;
   localparam int unsigned ADDR_W = 5;

   // words held by each scratchpad copy
   localparam int unsigned MMEM_DEPTH = 32;

   // edges from issue to registered result
   localparam int unsigned RESULT_LATENCY = 2;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [DATA_W-1:0] word_t;
   typedef logic [ADDR_W-1:0] maddr_t;

   // micro-instruction alu field
   typedef enum logic [2:0]
   {
      OP_ADD    = 3'd0,
      OP_SUB    = 3'd1,
      OP_AND    = 3'd2,
      OP_OR     = 3'd3,
      OP_XOR    = 3'd4,
      OP_PASS_M = 3'd5,
      OP_PASS_A = 3'd6,
      OP_SHL_M  = 3'd7
   } alu_op_t;

endpackage

`default_nettype wire

// ==== mmem_unit.sv ====
// scratchpad slice top: mirrored m/a memories, operand fetch and alu stage
`timescale 1ns/100ps
`default_nettype none

module mmem_unit
(
   input  logic              clk_a,
   input  logic              reset,

   input  logic              issue,
   input  mmem_pkg::maddr_t  m_src,
   input  mmem_pkg::maddr_t  a_src,
   input  mmem_pkg::maddr_t  dest,
   input  mmem_pkg::alu_op_t alu_op,

   input  logic              load_en,
   input  mmem_pkg::maddr_t  load_addr,
   input  mmem_pkg::word_t   load_data,

   output logic              result_valid,
   output mmem_pkg::word_t   result,
   output mmem_pkg::maddr_t  result_dest
);

   import mmem_pkg::*;

   word_t   m_q;
   word_t   a_q;
   maddr_t  m_addr;
   maddr_t  a_addr;
   logic    m_rden;
   logic    op_valid;
   word_t   op_m;
   word_t   op_a;
   maddr_t  op_dest;
   alu_op_t op_alu;

   // port a shared by host load and operand read
   assign m_addr = load_en ? load_addr : m_src;
   assign a_addr = load_en ? load_addr : a_src;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // mirrored scratchpad, writeback on port b
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   part_32x32dpram m_mem
   (
      .reset     (reset),
      .clk_a     (clk_a),
      .address_a (m_addr),
      .data_a    (load_data),
      .wren_a    (load_en),
      .rden_a    (m_rden),
      .q_a       (m_q),
      .clk_b     (clk_a),
      .address_b (result_dest),
      .data_b    (result),
      .wren_b    (result_valid),
      .rden_b    (1'b0),
      .q_b       ()
   );

   part_32x32dpram a_mem
   (
      .reset     (reset),
      .clk_a     (clk_a),
      .address_a (a_addr),
      .data_a    (load_data),
      .wren_a    (load_en),
      .rden_a    (m_rden),
      .q_a       (a_q),
      .clk_b     (clk_a),
      .address_b (result_dest),
      .data_b    (result),
      .wren_b    (result_valid),
      .rden_b    (1'b0),
      .q_b       ()
   );

   operand_fetch u_fetch
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .issue     (issue),
      .m_src     (m_src),
      .a_src     (a_src),
      .dest      (dest),
      .alu_op    (alu_op),
      .m_q       (m_q),
      .a_q       (a_q),
      .res_valid (result_valid),
      .res_dest  (result_dest),
      .res_data  (result),
      .load_en   (load_en),
      .m_rden    (m_rden),
      .op_valid  (op_valid),
      .op_m      (op_m),
      .op_a      (op_a),
      .op_dest   (op_dest),
      .op_alu    (op_alu)
   );

   alu_stage u_alu
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .op_valid  (op_valid),
      .op_m      (op_m),
      .op_a      (op_a),
      .op_dest   (op_dest),
      .op_alu    (op_alu),
      .res_valid (result_valid),
      .res_dest  (result_dest),
      .res_data  (result)
   );

endmodule

`default_nettype wire

// ==== operand_fetch.sv ====
// operand stage: starts the scratchpad reads and forwards the two newest results
`timescale 1ns/100ps
`default_nettype none

module operand_fetch
(
   input  logic              clk_a,
   input  logic              reset,

   // issued micro-instruction
   input  logic              issue,
   input  mmem_pkg::maddr_t  m_src,
   input  mmem_pkg::maddr_t  a_src,
   input  mmem_pkg::maddr_t  dest,
   input  mmem_pkg::alu_op_t alu_op,

   // registered ram outputs
   input  mmem_pkg::word_t   m_q,
   input  mmem_pkg::word_t   a_q,

   // result register
   input  logic              res_valid,
   input  mmem_pkg::maddr_t  res_dest,
   input  mmem_pkg::word_t   res_data,

   input  logic              load_en,

   output logic              m_rden,
   output logic              op_valid,
   output mmem_pkg::word_t   op_m,
   output mmem_pkg::word_t   op_a,
   output mmem_pkg::maddr_t  op_dest,
   output mmem_pkg::alu_op_t op_alu
);

   import mmem_pkg::*;

   maddr_t m_src_q;
   maddr_t a_src_q;

   // result written to ram on the same edge as the current read
   logic   ret_valid;
   maddr_t ret_dest;
   word_t  ret_data;

   logic   m_hit_res;
   logic   a_hit_res;
   logic   m_hit_ret;
   logic   a_hit_ret;

   // both copies read on the issue edge
   assign m_rden = issue;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stage registers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         op_valid  <= 1'b0;
         ret_valid <= 1'b0;
      end
      else
      begin
         op_valid  <= issue;
         ret_valid <= res_valid;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (issue)
      begin
         m_src_q <= m_src;
         a_src_q <= a_src;
         op_dest <= dest;
         op_alu  <= alu_op;
      end
      ret_dest <= res_dest;
      ret_data <= res_data;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // forwarding, newest result first
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign m_hit_res = res_valid && (res_dest == m_src_q);
   assign a_hit_res = res_valid && (res_dest == a_src_q);
   assign m_hit_ret = ret_valid && (ret_dest == m_src_q);
   assign a_hit_ret = ret_valid && (ret_dest == a_src_q);

   assign op_m = m_hit_res ? res_data : (m_hit_ret ? ret_data : m_q);
   assign op_a = a_hit_res ? res_data : (a_hit_ret ? ret_data : a_q);

   // host load needs three idle cycles after the last issue
   a_load_quiet : assert property (@(posedge clk_a) disable iff (reset)
      load_en |-> !issue && !$past(issue) && !$past(issue, 2) && !$past(issue, 3))
      else $error("host load too close to an issued instruction");

endmodule

`default_nettype wire

// ==== part_32x32dpram.sv ====
// 32x32 dual port synchronous ram, port a write wins; one copy per scratchpad operand
`timescale 1ns/100ps
`default_nettype none

module part_32x32dpram
(
   input  logic             reset,

   input  logic             clk_a,
   input  mmem_pkg::maddr_t address_a,
   input  mmem_pkg::word_t  data_a,
   input  logic             wren_a,
   input  logic             rden_a,
   output mmem_pkg::word_t  q_a,

   input  logic             clk_b,
   input  mmem_pkg::maddr_t address_b,
   input  mmem_pkg::word_t  data_b,
   input  logic             wren_b,
   input  logic             rden_b,
   output mmem_pkg::word_t  q_b
);

   import mmem_pkg::*;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // storage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   word_t ram [MMEM_DEPTH];
   word_t out_a;
   word_t out_b;

   assign q_a = out_a;
   assign q_b = out_b;

   // single write per edge, port b dropped on a collision
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         ram[address_a] <= data_a;
      end
      else if (wren_b)
      begin
         ram[address_b] <= data_b;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // read registers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // old data on read during write
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         out_a <= '0;
      end
      else if (rden_a)
      begin
         out_a <= ram[address_a];
      end
   end

   always_ff @(posedge clk_b)
   begin
      if (reset)
      begin
         out_b <= '0;
      end
      else if (rden_b)
      begin
         out_b <= ram[address_b];
      end
   end

   // host load and writeback must never collide
   a_no_dual_write : assert property (@(posedge clk_a) disable iff (reset)
      !(wren_a && wren_b))
      else $error("both ports written in one cycle, port b write lost");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/bash
# build and run the scratchpad slice testbench with verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module tb_mmem_unit -o sim_mmem \
   && ./obj_dir/sim_mmem > sim.log 2>&1 \
   || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "All tests passed!" sim.log && exit 0 || exit 1

// ==== src.f ====
mmem_pkg.sv
part_32x32dpram.sv
operand_fetch.sv
alu_stage.sv
mmem_unit.sv
mmem_checker.sv
tb_mmem_unit.sv

// ==== tb_mmem_unit.sv ====
// testbench top that drives the scratchpad slice and predicts its results from a shadow copy
`timescale 1ns/100ps
`default_nettype none

module tb_mmem_unit;

   import mmem_pkg::*;

   localparam int RESET_CYCLES = 8;
   localparam int QUIET_CYCLES = 4;
   localparam int CHAIN_LEN    = 16;
   localparam int GROUPS       = 8;
   localparam int STREAM_LEN   = 200;

   // cycle budget of each test with worst case stream gaps
   localparam int LOAD_BUDGET  = 2 * (QUIET_CYCLES + MMEM_DEPTH + 1);
   localparam int PASS_BUDGET  = 2 * MMEM_DEPTH * 3;
   localparam int OPS_BUDGET   = 8 * 4 * 3;
   localparam int FWD_BUDGET   = CHAIN_LEN + 2 + GROUPS * 10;
   localparam int TEST_CYCLES  = RESET_CYCLES + QUIET_CYCLES + LOAD_BUDGET + PASS_BUDGET
                                 + OPS_BUDGET + FWD_BUDGET + 2 * STREAM_LEN + RESULT_LATENCY + 2;
   localparam int TIMEOUT_CYCLES = TEST_CYCLES + 50;

   logic    clk_a;
   logic    reset;
   logic    issue;
   maddr_t  m_src;
   maddr_t  a_src;
   maddr_t  dest;
   alu_op_t alu_op;
   logic    load_en;
   maddr_t  load_addr;
   word_t   load_data;
   logic    result_valid;
   word_t   result;
   maddr_t  result_dest;

   word_t  shadow [MMEM_DEPTH];
   integer seed = 32'hd6a2;
   int     cycle_count = 0;
   int     other_errors = 0;
   int     total_errors;

   mmem_unit DUT
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .issue        (issue),
      .m_src        (m_src),
      .a_src        (a_src),
      .dest         (dest),
      .alu_op       (alu_op),
      .load_en      (load_en),
      .load_addr    (load_addr),
      .load_data    (load_data),
      .result_valid (result_valid),
      .result       (result),
      .result_dest  (result_dest)
   );

   mmem_checker chk
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .issue        (issue),
      .result_valid (result_valid),
      .result       (result),
      .result_dest  (result_dest)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #50 clk_a = ~clk_a;
   end

   always @(posedge clk_a)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failures found");
         $finish;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reference model and stimulus helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic word_t ref_alu(input alu_op_t op, input word_t m, input word_t a);
      case (op)
         OP_ADD:    ref_alu = m + a;
         OP_SUB:    ref_alu = m - a;
         OP_AND:    ref_alu = m & a;
         OP_OR:     ref_alu = m | a;
         OP_XOR:    ref_alu = m ^ a;
         OP_PASS_M: ref_alu = m;
         OP_PASS_A: ref_alu = a;
         default:   ref_alu = m << 1;
      endcase
   endfunction

   function automatic word_t rand_word();
      rand_word = $random(seed);
   endfunction

   function automatic maddr_t rand_addr();
      word_t r;
      r = $random(seed);
      rand_addr = r[ADDR_W-1:0];
   endfunction

   function automatic alu_op_t rand_op();
      word_t r;
      r = $random(seed);
      rand_op = alu_op_t'(r[2:0]);
   endfunction

   // every address bit shows up in the word
   function automatic word_t pattern_word(input maddr_t addr);
      pattern_word = {addr, 3'b101, ~addr, 3'b010, addr, 3'b110, ~addr, 3'b011};
   endfunction

   task automatic next_cycle();
      @(posedge clk_a);
      #10;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles)
      begin
         next_cycle();
         issue   = 1'b0;
         load_en = 1'b0;
      end
   endtask

   task automatic do_load(input maddr_t addr, input word_t data);
      next_cycle();
      issue     = 1'b0;
      load_en   = 1'b1;
      load_addr = addr;
      load_data = data;
      shadow[addr] = data;
   endtask

   task automatic load_all(input logic use_random);
      idle(QUIET_CYCLES);
      for (int i = 0; i < MMEM_DEPTH; i++)
      begin
         do_load(maddr_t'(i), use_random ? rand_word() : pattern_word(maddr_t'(i)));
      end
      idle(1);
   endtask

   // shadow follows issue order
   task automatic do_issue(input string name, input maddr_t m, input maddr_t a,
                           input maddr_t d, input alu_op_t op);
      word_t expected;
      next_cycle();
      load_en = 1'b0;
      issue   = 1'b1;
      m_src   = m;
      a_src   = a;
      dest    = d;
      alu_op  = op;
      expected = ref_alu(op, shadow[m], shadow[a]);
      chk.push_expected(name, expected, d);
      shadow[d] = expected;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial
   begin
      maddr_t prev;
      maddr_t next;
      maddr_t a_sel;
      maddr_t x;
      maddr_t y;
      maddr_t u;
      word_t  r;

      reset     = 1'b1;
      issue     = 1'b0;
      m_src     = '0;
      a_src     = '0;
      dest      = '0;
      alu_op    = OP_ADD;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;

      repeat (RESET_CYCLES)
      begin
         next_cycle();
         if (result_valid !== 1'b0)
         begin
            $display("result_valid is not low during reset");
            other_errors++;
         end
      end
      reset = 1'b0;
      repeat (QUIET_CYCLES)
      begin
         next_cycle();
         if (result_valid !== 1'b0)
         begin
            $display("result_valid went high before the first issue");
            other_errors++;
         end
      end

      // a copy read back from the pattern load
      load_all(1'b0);
      for (int i = 0; i < MMEM_DEPTH; i++)
      begin
         do_issue("load_pass_a", rand_addr(), maddr_t'(i), maddr_t'(i), OP_PASS_A);
         idle(2);
      end

      // m copy read back from a random load, kept for the alu ops
      load_all(1'b1);
      for (int i = 0; i < MMEM_DEPTH; i++)
      begin
         do_issue("load_pass_m", maddr_t'(i), rand_addr(), maddr_t'(i), OP_PASS_M);
         idle(2);
      end

      for (int op = 0; op < 8; op++)
      begin
         for (int k = 0; k < 4; k++)
         begin
            do_issue("alu_ops", rand_addr(), rand_addr(), rand_addr(), alu_op_t'(op));
            idle(2);
         end
      end

      prev = rand_addr();
      for (int k = 0; k < CHAIN_LEN; k++)
      begin
         next = rand_addr();
         a_sel = (k % 2 == 0) ? rand_addr() : prev;
         do_issue("fwd_result", prev, a_sel, next, rand_op());
         prev = next;
      end
      idle(2);

      // y and u never equal x
      for (int k = 0; k < GROUPS; k++)
      begin
         x = rand_addr();
         y = x ^ 5'h10;
         u = x ^ 5'h08;
         do_issue("fwd_retired", rand_addr(), rand_addr(), x, rand_op());
         do_issue("fwd_retired", y, u, y, rand_op());
         do_issue("fwd_retired", x, x, rand_addr(), rand_op());
         idle(2);
         do_issue("fwd_newest", rand_addr(), rand_addr(), x, rand_op());
         do_issue("fwd_newest", y, u, x, rand_op());
         do_issue("fwd_newest", x, x, u, rand_op());
         idle(2);
      end

      for (int k = 0; k < STREAM_LEN; k++)
      begin
         do_issue("random_stream", rand_addr(), rand_addr(), rand_addr(), rand_op());
         r = rand_word();
         if (r[1:0] == 2'b00)
         begin
            idle(1);
         end
      end
      idle(RESULT_LATENCY + 2);
      chk.report_pending();

      total_errors = chk.mismatch_count + chk.timing_count + chk.missing_count + other_errors;
      $display("errors: mismatch %0d, timing %0d, missing %0d, other %0d",
               chk.mismatch_count, chk.timing_count, chk.missing_count, other_errors);
      if (total_errors == 0)
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire
